// ==== tb.f ====
+incdir+include
logic/bus_pkg.sv
logic/bus_arbiter.sv
logic/bus_ram.sv
logic/bus_mailbox.sv
logic/bus_system.sv
sim/tb_bus_system.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the bus system testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f tb.f --top-module tb_bus_system -o sim_tb || exit 1
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "^Finished with no errors$" sim.log && echo "simulation passed" || {
  echo "simulation failed"
  exit 1
}

// ==== sim/tb_bus_system.sv ====
`timescale 1ns/10ps
`include "bus_defs.svh"

module tb_bus_system
  import bus_pkg::*;
();

  localparam int MAX_ENTRIES = 64;
  localparam int ACK_WAIT = 40;

  logic      clk;
  logic      reset;
  logic      m0_req;
  bus_ctrl_t m0_ctrl;
  bus_data_t m0_wdata;
  logic      m1_req;
  bus_ctrl_t m1_ctrl;
  bus_data_t m1_wdata;
  logic      m0_ack;
  logic      m0_reply_valid;
  bus_data_t m0_reply_data;
  logic      m1_ack;
  logic      m1_reply_valid;
  bus_data_t m1_reply_data;

  // stimulus table, one slot per transfer
  int        t_phase [MAX_ENTRIES];
  int        t_master [MAX_ENTRIES];
  logic      t_write [MAX_ENTRIES];
  dev_id_t   t_id [MAX_ENTRIES];
  dev_addr_t t_addr [MAX_ENTRIES];
  bus_data_t t_data [MAX_ENTRIES];
  bus_data_t t_exp [MAX_ENTRIES];
  int        n_entries = 0;
  int        n_phases = 0;

  bus_data_t ram_model [16];
  bus_data_t mbox_model [$];
  logic [31:0] lcg_state = 32'he3d2_b1b7;

  int errors = 0;
  int tests_ok = 0;
  int tests_bad = 0;

  // arbitration monitor state
  logic arb_active = 1'b0;
  int   cyc = 0;
  int   n_ack = 0;
  int   first_ack = -1;
  int   last_ack = -1;
  logic first_m1 = 1'b0;
  logic prev_m0_ack = 1'b0;
  logic prev_m1_ack = 1'b0;

  bus_system dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // expected value follows the device rules in table order
  task automatic add_entry(input int phase, input int m, input logic wr, input int id,
                           input int addr, input logic [31:0] data);
    bus_data_t exp;
    exp = '0;
    if (id == `RAM_BUS_ID) begin
      if (wr) begin
        ram_model[addr] = data;
      end else begin
        exp = ram_model[addr];
      end
    end else if (id == `MBOX_BUS_ID) begin
      if (addr != 0) begin
        if (!wr) exp = mbox_model.size();
      end else if (wr) begin
        if (mbox_model.size() < `MBOX_DEPTH) mbox_model.push_back(data);
      end else if (mbox_model.size() > 0) begin
        exp = mbox_model.pop_front();
      end
    end
    t_phase[n_entries] = phase;
    t_master[n_entries] = m;
    t_write[n_entries] = wr;
    t_id[n_entries] = dev_id_t'(id);
    t_addr[n_entries] = dev_addr_t'(addr);
    t_data[n_entries] = data;
    t_exp[n_entries] = exp;
    n_entries++;
    if (phase + 1 > n_phases) n_phases = phase + 1;
  endtask

  task automatic build_table();
    int p;
    for (int i = 0; i < 8; i++) begin
      add_entry(0, 0, 1'b1, `RAM_BUS_ID, i, lcg_next());
      add_entry(0, 1, 1'b1, `RAM_BUS_ID, i + 8, lcg_next());
    end
    for (int i = 0; i < 8; i++) begin
      add_entry(1, 0, 1'b0, `RAM_BUS_ID, i + 8, 0);
      add_entry(1, 1, 1'b0, `RAM_BUS_ID, i, 0);
    end
    p = 2;
    for (int i = 0; i < 5; i++) begin
      add_entry(p, i % 2, 1'b1, `MBOX_BUS_ID, 0, lcg_next()); // fifth one is dropped
      add_entry(p + 1, 1, 1'b0, `MBOX_BUS_ID, 1, 0);
      p += 2;
    end
    for (int i = 0; i < 5; i++) begin
      add_entry(p + i, (i + 1) % 2, 1'b0, `MBOX_BUS_ID, 0, 0); // last pops empty
    end
    p += 5;
    add_entry(p, 0, 1'b0, `MBOX_BUS_ID, 2, 0);
    add_entry(p + 1, 0, 1'b1, 5, 3, lcg_next());
    add_entry(p + 1, 0, 1'b1, 5, 0, lcg_next()); // lone master asks again right after ack
    add_entry(p + 2, 1, 1'b0, 5, 3, 0);
    add_entry(p + 3, 1, 1'b0, `RAM_BUS_ID, 3, 0);
    add_entry(p + 4, 0, 1'b0, `MBOX_BUS_ID, 1, 0);
  endtask

  task automatic drive_master(input int m, input logic req, input bus_ctrl_t ctrl,
                              input bus_data_t wdata);
    if (m == 0) begin
      m0_req = req;
      m0_ctrl = ctrl;
      m0_wdata = wdata;
    end else begin
      m1_req = req;
      m1_ctrl = ctrl;
      m1_wdata = wdata;
    end
  endtask

  // called on a falling edge, returns on a falling edge
  task automatic run_entry(input int e);
    int m;
    int tries;
    int err0;
    logic got_ack;
    logic rv;
    bus_data_t rd;
    m = t_master[e];
    err0 = errors;
    got_ack = 1'b0;
    drive_master(m, 1'b1, {t_id[e], t_write[e], t_addr[e]}, t_data[e]);
    for (tries = 0; tries < ACK_WAIT && !got_ack; tries++) begin
      @(negedge clk);
      got_ack = (m == 0) ? m0_ack : m1_ack;
    end
    drive_master(m, 1'b0, '0, '0);
    if (!got_ack) begin
      $display("test %0d: master %0d never received an ack", e, m);
      errors++;
    end else if (!t_write[e]) begin
      rv = (m == 0) ? m0_reply_valid : m1_reply_valid;
      if (rv !== 1'b0) begin
        $display("[ERROR] test %0d: m%0d_reply_valid exp 0x0 got 0x%h in ack cycle", e, m, rv);
        errors++;
      end
      @(negedge clk);
      rv = (m == 0) ? m0_reply_valid : m1_reply_valid;
      rd = (m == 0) ? m0_reply_data : m1_reply_data;
      if (rv !== 1'b1) begin
        $display("test %0d: master %0d got no reply one cycle after ack", e, m);
        errors++;
      end else if (rd !== t_exp[e]) begin
        $display("[ERROR] test %0d: m%0d_reply_data exp 0x%08h got 0x%08h",
                 e, m, t_exp[e], rd);
        errors++;
      end
    end
    if (errors == err0) begin
      tests_ok++;
      $display("test %0d m%0d %s id %0d addr %0h ok", e, m, t_write[e] ? "wr" : "rd",
               t_id[e], t_addr[e]);
    end else begin
      tests_bad++;
      $display("test %0d m%0d failed", e, m);
    end
  endtask

  task automatic run_master_phase(input int m, input int p);
    for (int e = 0; e < n_entries; e++) begin
      if (t_phase[e] == p && t_master[e] == m) run_entry(e);
    end
  endtask

  always @(negedge clk) begin
    if (!reset) begin
      cyc++;
      if (m0_ack && m1_ack) begin
        $display("[ERROR] m0_ack and m1_ack both 0x1 in cycle %0d", cyc);
        errors++;
      end
      if ((m0_ack && prev_m0_ack) || (m1_ack && prev_m1_ack)) begin
        $display("a master received back-to-back acks in cycle %0d", cyc);
        errors++;
      end
      if (arb_active && (m0_ack || m1_ack)) begin
        if (first_ack < 0) begin
          first_ack = cyc;
          first_m1 = m1_ack;
        end
        last_ack = cyc;
        n_ack++;
      end
      prev_m0_ack = m0_ack;
      prev_m1_ack = m1_ack;
    end
  end

  initial begin
    wait (n_entries > 0);
    repeat (n_entries * 4 + 100) @(posedge clk);
    $display("timeout: the run did not complete in time");
    $display("Finished with errors");
    $finish;
  end

  initial begin
    reset = 1'b1;
    drive_master(0, 1'b0, '0, '0);
    drive_master(1, 1'b0, '0, '0);
    for (int i = 0; i < 16; i++) ram_model[i] = 'x;
    build_table();
    repeat (8) @(negedge clk);
    reset = 1'b0;
    repeat (3) begin
      @(negedge clk);
      if ({m0_ack, m1_ack, m0_reply_valid, m1_reply_valid} !== 4'b0000) begin
        $display("[ERROR] {m0_ack,m1_ack,m0_reply_valid,m1_reply_valid} exp 0x0 got 0x%h",
                 {m0_ack, m1_ack, m0_reply_valid, m1_reply_valid});
        errors++;
      end
    end
    for (int p = 0; p < n_phases; p++) begin
      arb_active = (p == 0);
      fork
        run_master_phase(0, p);
        run_master_phase(1, p);
      join
      @(negedge clk);
      if (p == 0) begin
        arb_active = 1'b0;
        if (n_ack != 16 || last_ack - first_ack + 1 != 16 || first_m1) begin
          $display("acks did not alternate every cycle starting with m0 (%0d acks)", n_ack);
          errors++;
        end
      end
    end
    $display("tests passed %0d, failed %0d, errors %0d", tests_ok, tests_bad, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== logic/bus_system.sv ====
`timescale 1ns/10ps

module bus_system
  import bus_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      m0_req,
  input  bus_ctrl_t m0_ctrl,
  input  bus_data_t m0_wdata,
  input  logic      m1_req,
  input  bus_ctrl_t m1_ctrl,
  input  bus_data_t m1_wdata,
  output logic      m0_ack,
  output logic      m0_reply_valid,
  output bus_data_t m0_reply_data,
  output logic      m1_ack,
  output logic      m1_reply_valid,
  output bus_data_t m1_reply_data
);

  // shared bus from the arbiter to both devices
  logic      bus_write;
  dev_addr_t bus_addr;
  bus_data_t bus_wdata;
  logic      ram_sel;
  logic      mbox_sel;
  bus_data_t ram_rdata;
  bus_data_t mbox_rdata;

  bus_arbiter arbiter0 (
    .clk            (clk),
    .reset          (reset),
    .m0_req         (m0_req),
    .m0_ctrl        (m0_ctrl),
    .m0_wdata       (m0_wdata),
    .m1_req         (m1_req),
    .m1_ctrl        (m1_ctrl),
    .m1_wdata       (m1_wdata),
    .ram_rdata      (ram_rdata),
    .mbox_rdata     (mbox_rdata),
    .m0_ack         (m0_ack),
    .m0_reply_valid (m0_reply_valid),
    .m0_reply_data  (m0_reply_data),
    .m1_ack         (m1_ack),
    .m1_reply_valid (m1_reply_valid),
    .m1_reply_data  (m1_reply_data),
    .bus_write      (bus_write),
    .bus_addr       (bus_addr),
    .bus_wdata      (bus_wdata),
    .ram_sel        (ram_sel),
    .mbox_sel       (mbox_sel)
  );

  bus_ram ram0 (
    .clk   (clk),
    .reset (reset),
    .sel   (ram_sel),
    .write (bus_write),
    .addr  (bus_addr),
    .wdata (bus_wdata),
    .rdata (ram_rdata)
  );

  bus_mailbox mbox0 (
    .clk   (clk),
    .reset (reset),
    .sel   (mbox_sel),
    .write (bus_write),
    .addr  (bus_addr),
    .wdata (bus_wdata),
    .rdata (mbox_rdata)
  );

endmodule

// ==== logic/bus_mailbox.sv ====
`timescale 1ns/10ps
`include "bus_defs.svh"

module bus_mailbox
  import bus_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      sel,
  input  logic      write,
  input  dev_addr_t addr,
  input  bus_data_t wdata,
  output bus_data_t rdata
);

  localparam int PTR_W = $clog2(`MBOX_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  bus_data_t        mem [0:`MBOX_DEPTH-1];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             empty;
  logic             fifo_sel;
  logic             push;
  logic             pop;

  assign full     = (count == CNT_W'(`MBOX_DEPTH));
  assign empty    = (count == '0);
  assign fifo_sel = (addr == '0); // anything else is the count register
  assign push     = sel && write && fifo_sel && !full;
  assign pop      = sel && !write && fifo_sel && !empty;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      rdata  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(`MBOX_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(`MBOX_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push) begin
        count <= count + 1'b1;
      end else if (pop) begin
        count <= count - 1'b1;
      end
      if (sel && !write) begin
        if (!fifo_sel) begin
          rdata <= bus_data_t'(count);
        end else if (empty) begin
          rdata <= '0; // pop on empty
        end else begin
          rdata <= mem[rd_ptr];
        end
      end
    end
  end

endmodule

// ==== logic/bus_ram.sv ====
`timescale 1ns/10ps
`include "bus_defs.svh"

module bus_ram
  import bus_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      sel,
  input  logic      write,
  input  dev_addr_t addr,
  input  bus_data_t wdata,
  output bus_data_t rdata
);

  localparam int WORDS = 1 << `BUS_ADDR_W;

  bus_data_t mem [0:WORDS-1];

  always_ff @(posedge clk) begin
    if (sel && write) begin
      mem[addr] <= wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rdata <= '0;
    end else if (sel && !write) begin
      rdata <= mem[addr]; // holds between reads
    end
  end

endmodule

// ==== logic/bus_arbiter.sv ====
`timescale 1ns/10ps
`include "bus_defs.svh"

module bus_arbiter
  import bus_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      m0_req,
  input  bus_ctrl_t m0_ctrl,
  input  bus_data_t m0_wdata,
  input  logic      m1_req,
  input  bus_ctrl_t m1_ctrl,
  input  bus_data_t m1_wdata,
  input  bus_data_t ram_rdata,
  input  bus_data_t mbox_rdata,
  output logic      m0_ack,
  output logic      m0_reply_valid,
  output bus_data_t m0_reply_data,
  output logic      m1_ack,
  output logic      m1_reply_valid,
  output bus_data_t m1_reply_data,
  output logic      bus_write,
  output dev_addr_t bus_addr,
  output bus_data_t bus_wdata,
  output logic      ram_sel,
  output logic      mbox_sel
);

  arb_state_t last_grant;
  logic       m0_elig;
  logic       m1_elig;
  logic       grant_m0;
  logic       grant_m1;
  logic       grant_any;
  bus_ctrl_t  win_ctrl;
  bus_data_t  win_wdata;
  dev_id_t    win_id;
  logic       reply_ram;
  logic       reply_mbox;
  bus_data_t  reply_data;

  assign m0_elig = m0_req && !m0_ack; // no back-to-back grant
  assign m1_elig = m1_req && !m1_ack;

  assign grant_m0  = m0_elig && (!m1_elig || last_grant == last_m1);
  assign grant_m1  = m1_elig && !grant_m0;
  assign grant_any = grant_m0 || grant_m1;

  assign win_ctrl  = grant_m1 ? m1_ctrl : m0_ctrl;
  assign win_wdata = grant_m1 ? m1_wdata : m0_wdata;
  assign win_id    = win_ctrl[`BUS_CTRL_W-1 -: `BUS_ID_W];

  always_ff @(posedge clk) begin
    if (reset) begin
      last_grant <= last_m1; // so m0 takes the first tie
      m0_ack     <= 1'b0;
      m1_ack     <= 1'b0;
      bus_write  <= 1'b0;
      ram_sel    <= 1'b0;
      mbox_sel   <= 1'b0;
    end else begin
      m0_ack    <= grant_m0;
      m1_ack    <= grant_m1;
      bus_write <= grant_any && win_ctrl[`BUS_ADDR_W];
      ram_sel   <= grant_any && (win_id == dev_id_t'(`RAM_BUS_ID));
      mbox_sel  <= grant_any && (win_id == dev_id_t'(`MBOX_BUS_ID));
      if (grant_m0) begin
        last_grant <= last_m0;
      end else if (grant_m1) begin
        last_grant <= last_m1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (grant_any) begin
      bus_addr  <= win_ctrl[`BUS_ADDR_W-1:0];
      bus_wdata <= win_wdata;
    end
  end

  // reply stage, one cycle behind ack
  always_ff @(posedge clk) begin
    if (reset) begin
      m0_reply_valid <= 1'b0;
      m1_reply_valid <= 1'b0;
      reply_ram      <= 1'b0;
      reply_mbox     <= 1'b0;
    end else begin
      m0_reply_valid <= m0_ack && !bus_write;
      m1_reply_valid <= m1_ack && !bus_write;
      reply_ram      <= ram_sel;
      reply_mbox     <= mbox_sel;
    end
  end

  always_comb begin
    if (reply_ram) begin
      reply_data = ram_rdata;
    end else if (reply_mbox) begin
      reply_data = mbox_rdata;
    end else begin
      reply_data = '0; // unmapped id reads zero
    end
  end

  assign m0_reply_data = reply_data;
  assign m1_reply_data = reply_data;

endmodule

// ==== logic/bus_pkg.sv ====
`include "bus_defs.svh"

package bus_pkg;

  typedef logic [`BUS_DATA_W-1:0] bus_data_t;

  // [7:5] dest id, [4] write, [3:0] word addr
  typedef logic [`BUS_CTRL_W-1:0] bus_ctrl_t;

  typedef logic [`BUS_ID_W-1:0] dev_id_t;
  typedef logic [`BUS_ADDR_W-1:0] dev_addr_t;

  typedef enum logic {
    last_m0,
    last_m1
  } arb_state_t;

endpackage

// ==== include/bus_defs.svh ====
`ifndef BUS_DEFS_SVH
`define BUS_DEFS_SVH

// word and control widths
`define BUS_DATA_W 32
`define BUS_CTRL_W 8
`define BUS_ADDR_W 4

// destination id field sits above the write bit
`define BUS_ID_W 3

// device ids on the shared bus
`define RAM_BUS_ID 0
`define MBOX_BUS_ID 1

`define MBOX_DEPTH 4

`endif
